// File: logic/boot_pkg.sv
`default_nettype none

package boot_pkg;

   typedef logic [23:0] flash_addr_t;   // Flash byte address
   typedef logic [15:0] mem_addr_t;     // Memory word address
   typedef logic [31:0] word_t;         // Data word or checksum
   typedef logic [7:0]  byte_t;
   typedef logic [15:0] word_count_t;   // Words per load

   typedef enum logic [1:0] {
      SPI_IDLE,
      SPI_COMMAND,                      // Command and address out
      SPI_RECEIVE,                      // Data bytes in
      SPI_FINISH                        // Release chip select
   } spi_state_t;

   typedef enum logic [1:0] {
      UART_IDLE,
      UART_START,
      UART_DATA,
      UART_STOP
   } uart_state_t;

   // Standard serial NOR read
   localparam byte_t FLASH_READ_CMD = 8'h03;

   // Boot image location in flash
   localparam flash_addr_t BOOT_FLASH_BASE = 24'h01_0000;

   localparam int unsigned SCK_HALF_CLKS = 2;       // clk cycles per SCK half period
   localparam int unsigned UART_CLKS_PER_BIT = 8;   // clk cycles per serial bit

endpackage

`default_nettype wire

// File: logic/spi_flash_reader.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_reader (
   input  wire                  clk,
   input  wire                  arst_n,
   input  wire                  start,
   input  boot_pkg::word_count_t word_count,
   input  wire                  spi_miso,
   output logic                 spi_sck,
   output logic                 spi_cs_n,
   output logic                 spi_mosi,
   output logic                 byte_valid,
   output boot_pkg::byte_t      rx_byte,
   output logic                 load_end
);

   import boot_pkg::*;

   spi_state_t  state;
   logic [3:0]  div_cnt;          // SCK half period divider
   logic        sck_tick;
   logic        sample_miso;
   logic [4:0]  bit_cnt;
   logic [31:0] cmd_shift;        // Command then address, MSB first
   logic [17:0] bytes_left;
   logic [6:0]  rx_shift;

   assign sck_tick    = (div_cnt == 4'(SCK_HALF_CLKS - 1));
   assign sample_miso = (state == SPI_RECEIVE) && sck_tick && !spi_sck;   // Rising SCK
   assign spi_mosi    = cmd_shift[31];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= SPI_IDLE;
         spi_sck    <= 1'b0;
         spi_cs_n   <= 1'b1;
         div_cnt    <= '0;
         bit_cnt    <= '0;
         cmd_shift  <= '0;
         bytes_left <= '0;
         byte_valid <= 1'b0;
         load_end   <= 1'b0;
      end else begin
         byte_valid <= 1'b0;
         load_end   <= 1'b0;

         if (state == SPI_COMMAND || state == SPI_RECEIVE) begin
            div_cnt <= sck_tick ? 4'd0 : div_cnt + 4'd1;
         end else begin
            div_cnt <= '0;
         end

         case (state)
            SPI_IDLE: begin
               if (start) begin
                  if (word_count == '0) begin
                     load_end <= 1'b1;                        // Empty load, flash untouched
                  end else begin
                     state      <= SPI_COMMAND;
                     spi_cs_n   <= 1'b0;
                     cmd_shift  <= {FLASH_READ_CMD, BOOT_FLASH_BASE};
                     bit_cnt    <= '0;
                     bytes_left <= {word_count, 2'b00};    // Four bytes per word
                  end
               end
            end

            SPI_COMMAND: begin
               if (sck_tick) begin
                  spi_sck <= ~spi_sck;
                  if (!spi_sck) begin
                     bit_cnt <= bit_cnt + 5'd1;
                  end else begin
                     cmd_shift <= {cmd_shift[30:0], 1'b0};  // Next bit on falling SCK
                     if (bit_cnt == '0) begin
                        state <= SPI_RECEIVE;                // All 32 bits sent
                     end
                  end
               end
            end

            SPI_RECEIVE: begin
               if (sck_tick) begin
                  spi_sck <= ~spi_sck;
                  if (!spi_sck) begin
                     bit_cnt <= bit_cnt + 5'd1;
                     if (bit_cnt[2:0] == 3'd7) begin
                        byte_valid <= 1'b1;
                        bytes_left <= bytes_left - 18'd1;
                     end
                  end else if (bytes_left == '0) begin
                     state <= SPI_FINISH;                    // SCK back low
                  end
               end
            end

            SPI_FINISH: begin
               spi_cs_n <= 1'b1;
               load_end <= 1'b1;
               state    <= SPI_IDLE;
            end

            default: state <= SPI_IDLE;
         endcase
      end
   end

   // Receive shifter, MSB first
   always_ff @(posedge clk) begin
      if (sample_miso) begin
         rx_shift <= {rx_shift[5:0], spi_miso};
         if (bit_cnt[2:0] == 3'd7) begin
            rx_byte <= {rx_shift, spi_miso};
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/boot_word_packer.sv
`timescale 1ns/1ps
`default_nettype none

module boot_word_packer (
   input  wire                clk,
   input  wire                arst_n,
   input  wire                start,
   input  wire                byte_valid,
   input  boot_pkg::byte_t    rx_byte,
   input  wire                load_end,
   output logic               mem_we,
   output boot_pkg::mem_addr_t mem_addr,
   output boot_pkg::word_t    mem_wdata,
   output logic               sum_valid,
   output boot_pkg::word_t    checksum
);

   import boot_pkg::*;

   logic        loading;          // Between accepted start and load_end
   logic        new_load;
   logic [1:0]  lane;             // Byte position in current word
   logic        word_done;
   mem_addr_t   wr_ptr;
   logic [23:0] word_lo;          // Bytes 0 to 2 of current word
   word_t       full_word;

   assign new_load  = start && !loading;
   assign word_done = byte_valid && (lane == 2'd3);
   assign full_word = {rx_byte, word_lo};   // Little-endian, last byte on top

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         loading   <= 1'b0;
         lane      <= '0;
         wr_ptr    <= '0;
         mem_addr  <= '0;
         mem_we    <= 1'b0;
         sum_valid <= 1'b0;
      end else begin
         mem_we    <= word_done;
         sum_valid <= load_end;
         if (new_load) begin
            loading  <= 1'b1;
            lane     <= '0;
            wr_ptr   <= '0;
            mem_addr <= '0;
         end else begin
            if (load_end) begin
               loading <= 1'b0;
            end
            if (byte_valid) begin
               lane <= lane + 2'd1;
            end
            if (word_done) begin
               mem_addr <= wr_ptr;
               wr_ptr   <= wr_ptr + 16'd1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (new_load) begin
         checksum <= '0;
      end else if (word_done) begin
         checksum <= checksum ^ full_word;   // Fold in each written word
      end
      if (byte_valid) begin
         case (lane)
            2'd0:    word_lo[7:0]   <= rx_byte;
            2'd1:    word_lo[15:8]  <= rx_byte;
            2'd2:    word_lo[23:16] <= rx_byte;
            default: mem_wdata      <= full_word;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: logic/uart_status_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_status_tx (
   input  wire             clk,
   input  wire             arst_n,
   input  wire             start,
   input  wire             sum_valid,
   input  boot_pkg::word_t checksum,
   output logic            uart_tx,
   output logic            busy,
   output logic            done
);

   import boot_pkg::*;

   uart_state_t state;
   logic [3:0]  bit_timer;
   logic        bit_end;
   logic [2:0]  bit_idx;
   logic [1:0]  byte_idx;
   logic        load_word;
   logic        shift_word;
   word_t       tx_word;          // Shifted right, LSB goes out next

   assign bit_end    = (bit_timer == 4'(UART_CLKS_PER_BIT - 1));
   assign load_word  = (state == UART_IDLE) && sum_valid;
   assign shift_word = bit_end && (state == UART_START ||
                       (state == UART_DATA && bit_idx != 3'd7));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= UART_IDLE;
         bit_timer <= '0;
         bit_idx   <= '0;
         byte_idx  <= '0;
         uart_tx   <= 1'b1;
         busy      <= 1'b0;
         done      <= 1'b0;
      end else begin
         done <= 1'b0;
         if (start) begin
            busy <= 1'b1;
         end

         if (state == UART_IDLE || bit_end) begin
            bit_timer <= '0;
         end else begin
            bit_timer <= bit_timer + 4'd1;
         end

         case (state)
            UART_IDLE: begin
               if (sum_valid) begin
                  state    <= UART_START;
                  byte_idx <= '0;
                  uart_tx  <= 1'b0;
               end
            end

            UART_START: begin
               if (bit_end) begin
                  state   <= UART_DATA;
                  bit_idx <= '0;
                  uart_tx <= tx_word[0];
               end
            end

            UART_DATA: begin
               if (bit_end) begin
                  if (bit_idx == 3'd7) begin
                     state   <= UART_STOP;
                     uart_tx <= 1'b1;
                  end else begin
                     bit_idx <= bit_idx + 3'd1;
                     uart_tx <= tx_word[0];
                  end
               end
            end

            UART_STOP: begin
               if (bit_end) begin
                  if (byte_idx == 2'd3) begin
                     state <= UART_IDLE;
                     done  <= 1'b1;
                     busy  <= 1'b0;                  // Sequence complete
                  end else begin
                     state    <= UART_START;
                     byte_idx <= byte_idx + 2'd1;
                     uart_tx  <= 1'b0;
                  end
               end
            end

            default: state <= UART_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (load_word) begin
         tx_word <= checksum;
      end else if (shift_word) begin
         tx_word <= {1'b0, tx_word[31:1]};
      end
   end

endmodule

`default_nettype wire

// File: logic/boot_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module boot_loader_top (
   input  wire                   clk,
   input  wire                   arst_n,
   input  wire                   start,
   input  boot_pkg::word_count_t word_count,
   output logic                  spi_sck,
   output logic                  spi_cs_n,
   output logic                  spi_mosi,
   input  wire                   spi_miso,
   output logic                  mem_we,
   output boot_pkg::mem_addr_t   mem_addr,
   output boot_pkg::word_t       mem_wdata,
   output logic                  busy,
   output logic                  done,
   output logic                  uart_tx
);

   import boot_pkg::*;

   logic  byte_valid;
   byte_t rx_byte;
   logic  load_end;
   logic  sum_valid;
   word_t checksum;

   spi_flash_reader i_reader (
      .clk        (clk),
      .arst_n     (arst_n),
      .start      (start),
      .word_count (word_count),
      .spi_miso   (spi_miso),
      .spi_sck    (spi_sck),
      .spi_cs_n   (spi_cs_n),
      .spi_mosi   (spi_mosi),
      .byte_valid (byte_valid),
      .rx_byte    (rx_byte),
      .load_end   (load_end)
   );

   boot_word_packer i_packer (
      .clk        (clk),
      .arst_n     (arst_n),
      .start      (start),
      .byte_valid (byte_valid),
      .rx_byte    (rx_byte),
      .load_end   (load_end),
      .mem_we     (mem_we),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .sum_valid  (sum_valid),
      .checksum   (checksum)
   );

   uart_status_tx i_status (
      .clk        (clk),
      .arst_n     (arst_n),
      .start      (start),
      .sum_valid  (sum_valid),
      .checksum   (checksum),
      .uart_tx    (uart_tx),
      .busy       (busy),
      .done       (done)
   );

endmodule

`default_nettype wire

// File: verification/spi_flash_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_flash_model (
   input  wire         sck,
   input  wire         cs_n,
   input  wire         mosi,
   output logic        miso,
   output int unsigned protocol_errors
);

   import boot_pkg::*;

   logic [31:0] cmd_in;           // Command and address as received
   int unsigned bits_in;
   flash_addr_t rd_addr;
   logic [2:0]  out_bit;
   byte_t       rd_byte;

   initial begin
      miso            = 1'b0;
      protocol_errors = 0;
      bits_in         = 0;
   end

   always @(negedge cs_n) begin
      bits_in = 0;                // New transaction
   end

   // Command and address in on rising SCK
   always @(posedge sck) begin
      if (!cs_n && bits_in < 32) begin
         cmd_in  = {cmd_in[30:0], mosi};
         bits_in = bits_in + 1;
         if (bits_in == 32) begin
            if (cmd_in[31:24] != FLASH_READ_CMD) begin
               $display("Flash model: command %h at %0t is not a READ", cmd_in[31:24], $time);
               protocol_errors++;
            end
            if (cmd_in[23:0] != BOOT_FLASH_BASE) begin
               $display("Flash model: address %h at %0t is not the boot base",
                        cmd_in[23:0], $time);
               protocol_errors++;
            end
            rd_addr = cmd_in[23:0];
            out_bit = 3'd7;
         end
      end
   end

   // Data out on falling SCK, MSB first
   always @(negedge sck) begin
      if (!cs_n && bits_in == 32) begin
         rd_byte = rd_addr[7:0] ^ 8'h5a;
         miso    = rd_byte[out_bit];
         if (out_bit == 3'd0) begin
            rd_addr = rd_addr + 24'd1;
         end
         out_bit = out_bit - 3'd1;
      end
   end

endmodule

`default_nettype wire

// File: verification/tb_boot_loader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_boot_loader;

   import boot_pkg::*;

   logic        clk;
   logic        arst_n;
   logic        start;
   word_count_t word_count;
   logic        spi_sck;
   logic        spi_cs_n;
   logic        spi_mosi;
   logic        spi_miso;
   logic        mem_we;
   mem_addr_t   mem_addr;
   word_t       mem_wdata;
   logic        busy;
   logic        done;
   logic        uart_tx;

   mem_addr_t   wr_addr_q[$];     // Captured memory writes
   word_t       wr_data_q[$];
   byte_t       uart_q[$];        // Decoded UART bytes
   int unsigned errors = 0;
   int unsigned flash_errors;
   int unsigned cycle_cnt = 0;
   int unsigned cycle_limit = 0;
   int unsigned writes_at_done;
   int unsigned bytes_at_done;
   logic        busy_before_done;
   logic        busy_at_done;

   boot_loader_top i_dut (
      .clk        (clk),
      .arst_n     (arst_n),
      .start      (start),
      .word_count (word_count),
      .spi_sck    (spi_sck),
      .spi_cs_n   (spi_cs_n),
      .spi_mosi   (spi_mosi),
      .spi_miso   (spi_miso),
      .mem_we     (mem_we),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .busy       (busy),
      .done       (done),
      .uart_tx    (uart_tx)
   );

   spi_flash_model i_flash (
      .sck             (spi_sck),
      .cs_n            (spi_cs_n),
      .mosi            (spi_mosi),
      .miso            (spi_miso),
      .protocol_errors (flash_errors)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Little-endian word from the flash pattern at the boot base
   function automatic word_t expected_word(input int unsigned idx);
      flash_addr_t a;
      word_t       w;
      for (int j = 0; j < 4; j++) begin
         a = BOOT_FLASH_BASE + flash_addr_t'(4 * idx + j);
         w[8*j +: 8] = a[7:0] ^ 8'h5a;
      end
      return w;
   endfunction

   function automatic word_t expected_checksum(input word_count_t count);
      word_t sum;
      sum = '0;
      for (int i = 0; i < count; i++) begin
         sum = sum ^ expected_word(i);
      end
      return sum;
   endfunction

   function automatic int unsigned load_budget(input word_count_t count);
      return 64 * (4 * count + 32) + 40 * UART_CLKS_PER_BIT;
   endfunction

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic check_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
      if (act !== exp) begin
         $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic check_count(input string name, input word_count_t exp,
                              input word_count_t act);
      if (act !== exp) begin
         $display("** Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
         errors++;
      end
   endtask

   always @(negedge clk) begin
      if (mem_we) begin
         wr_addr_q.push_back(mem_addr);
         wr_data_q.push_back(mem_wdata);
      end
   end

   // 8N1 decoder sampling mid bit
   initial begin
      byte_t rx;
      forever begin
         @(negedge uart_tx);
         repeat (UART_CLKS_PER_BIT / 2) @(negedge clk);
         if (uart_tx !== 1'b0) begin
            $display("UART start bit too short at %0t", $time);
            errors++;
         end else begin
            for (int b = 0; b < 8; b++) begin
               repeat (UART_CLKS_PER_BIT) @(negedge clk);
               rx[b] = uart_tx;
            end
            repeat (UART_CLKS_PER_BIT) @(negedge clk);
            if (uart_tx !== 1'b1) begin
               $display("UART stop bit missing at %0t", $time);
               errors++;
            end
            uart_q.push_back(rx);
         end
      end
   end

   task automatic run_load(input word_count_t count, input bit extra_start);
      wr_addr_q.delete();
      wr_data_q.delete();
      uart_q.delete();
      @(negedge clk);
      start      = 1'b1;
      word_count = count;
      @(negedge clk);
      start      = 1'b0;
      check_bit("busy", 1'b1, busy);   // Cycle after start
      if (extra_start) begin
         while (wr_data_q.size() == 0) begin
            @(negedge clk);
         end
         @(negedge clk);
         start      = 1'b1;
         word_count = count + 16'd5;   // Must be ignored
         @(negedge clk);
         start      = 1'b0;
      end
      busy_before_done = busy;
      while (!done) begin
         busy_before_done = busy;
         @(negedge clk);
      end
      busy_at_done   = busy;
      writes_at_done = wr_data_q.size();
      bytes_at_done  = uart_q.size();
   endtask

   task automatic check_writes(input word_count_t count);
      check_count("write count", count, word_count_t'(writes_at_done));
      for (int i = 0; i < wr_data_q.size() && i < count; i++) begin
         check_addr("mem_addr", mem_addr_t'(i), wr_addr_q[i]);
         check_word("mem_wdata", expected_word(i), wr_data_q[i]);
      end
   endtask

   task automatic check_status(input word_count_t count);
      word_t sum;
      sum = '0;
      check_count("UART byte count", 16'd4, word_count_t'(bytes_at_done));
      if (uart_q.size() == 4) begin
         sum = {uart_q[3], uart_q[2], uart_q[1], uart_q[0]};
      end
      check_word("UART checksum", expected_checksum(count), sum);
   endtask

   task automatic test_reset_state;
      check_bit("spi_cs_n", 1'b1, spi_cs_n);
      check_bit("uart_tx", 1'b1, uart_tx);
      check_bit("spi_sck", 1'b0, spi_sck);
      check_bit("mem_we", 1'b0, mem_we);
      check_bit("busy", 1'b0, busy);
      check_bit("done", 1'b0, done);
   endtask

   task automatic test_four_words;
      run_load(16'd4, 1'b0);
      check_writes(16'd4);
   endtask

   task automatic test_random_count(input word_count_t count);
      run_load(count, 1'b0);
      check_writes(count);            // First address back at 0
   endtask

   task automatic test_uart_checksum;
      run_load(16'd5, 1'b0);
      check_writes(16'd5);
      check_status(16'd5);
      check_bit("busy before done", 1'b1, busy_before_done);
      check_bit("busy at done", 1'b0, busy_at_done);
   endtask

   task automatic test_start_while_busy;
      run_load(16'd3, 1'b1);
      check_writes(16'd3);
      check_status(16'd3);
   endtask

   task automatic test_zero_count;
      run_load(16'd0, 1'b0);
      check_writes(16'd0);
      check_status(16'd0);
   endtask

   initial begin
      word_count_t rand_count;
      arst_n     = 1'b0;
      start      = 1'b0;
      word_count = '0;
      void'($urandom(32'h81b6_8553));
      rand_count  = word_count_t'(1 + $urandom % 16);
      cycle_limit = 100 + load_budget(16'd4) + load_budget(rand_count) +
                    load_budget(16'd5) + load_budget(16'd3) + load_budget(16'd0);
      repeat (4) @(negedge clk);
      arst_n = 1'b1;
      test_reset_state();
      test_four_words();
      test_random_count(rand_count);
      test_uart_checksum();
      test_start_while_busy();
      test_zero_count();
      repeat (4) @(negedge clk);
      $display("Summary: %0d check errors, %0d flash protocol errors", errors, flash_errors);
      if (errors == 0 && flash_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // Limit covers every load of the run
   initial begin
      do begin
         @(posedge clk);
         cycle_cnt++;
      end while (cycle_cnt < cycle_limit);
      $display("Timeout after %0d cycles, a load never signalled done", cycle_cnt);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
logic/boot_pkg.sv
logic/spi_flash_reader.sv
logic/boot_word_packer.sv
logic/uart_status_tx.sv
logic/boot_loader_top.sv
verification/spi_flash_model.sv
verification/tb_boot_loader.sv
